// File: match_pkg.sv
// geometry of the page scanner: 8 pages of 12 bits per block, 4 blocks per scan
// widths below are derived, so changing the geometry only needs the first few values
// pages_per_block must stay a power of two, since page numbers are built by concatenation
`default_nettype none

package match_pkg;

  localparam int page_bits       = 12;                            // bits per page and pattern
  localparam int pages_per_block = 8;                             // parallel comparators
  localparam int blocks_per_scan = 4;                             // blocks in one scan
  localparam int num_patterns    = 4;                             // pattern slots

  localparam int block_bits      = page_bits * pages_per_block;   // 96 bit block bus
  localparam int total_pages     = pages_per_block * blocks_per_scan;
  localparam int page_num_bits   = $clog2(total_pages);           // global page number, 5
  localparam int page_sel_bits   = $clog2(pages_per_block);       // page inside block, 3
  localparam int block_idx_bits  = $clog2(blocks_per_scan);       // block index, 2
  localparam int count_bits      = $clog2(total_pages + 1);       // match count reaches 32, 6
  localparam int pcount_bits     = 3;                             // pattern count 0..7

  // scan sequencing
  typedef enum logic [1:0] {
    scan_idle  = 2'd0,  // waiting for start
    scan_load  = 2'd1,  // block_ready high, waiting for a block
    scan_drain = 2'd2,  // hits of the current block go out
    scan_done  = 2'd3   // one cycle done pulse
  } scan_state_t;

endpackage

`default_nettype wire

// File: scan_fsm.sv
// scan sequencer, one block in flight at a time
// start is ignored unless the FSM is idle (busy low)
// a block is only accepted after every hit of the previous block has gone out
// the enum literal scan_done is named with its package scope here,
// since the done output port carries the same name
`default_nettype none

module scan_fsm import match_pkg::*; (
  input  wire  clk,
  input  wire  rst,
  input  wire  start,          // one cycle pulse from host
  input  wire  block_valid,
  input  wire  last_block,     // current block is the last of the scan
  input  wire  hits_left,      // serializer still has pages to send
  output logic block_ready,
  output logic load_patterns,
  output logic clear_counts,
  output logic load_block,     // block handshake
  output logic advance_block,  // last drain cycle of a block
  output logic scan_done,
  output logic busy
);

  scan_state_t state, state_nxt;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= scan_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;  // hold by default
    unique case (state)
      scan_idle:  if (start) state_nxt = scan_load;
      scan_load:  if (block_valid) state_nxt = scan_drain;  // hit vector lands on this edge
      scan_drain: begin
        if (!hits_left) begin  // empty block costs exactly one cycle here
          state_nxt = last_block ? match_pkg::scan_done : scan_load;
        end
      end
      match_pkg::scan_done: state_nxt = scan_idle;  // pulse lasts one cycle
      default:    state_nxt = scan_idle;
    endcase
  end

  assign block_ready   = (state == scan_load);
  assign load_block    = block_ready & block_valid;
  assign load_patterns = (state == scan_idle) & start;  // patterns sampled on the start cycle
  assign clear_counts  = (state == scan_idle) & start;
  assign advance_block = (state == scan_drain) & ~hits_left;
  assign scan_done     = (state == match_pkg::scan_done);
  assign busy          = (state != scan_idle);  // drops the cycle after the done pulse

endmodule

`default_nettype wire

// File: block_counter.sv
// block index and match counter of one scan
// both clear on the start cycle; the match count holds after done until the next start
// the block index wraps to 0 after the last block
`default_nettype none

module block_counter import match_pkg::*; (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        clear_counts,   // start of a new scan
  input  wire                        advance_block,  // current block fully drained
  input  wire                        match_fire,     // one page sent
  output logic [block_idx_bits-1:0]  block_idx,
  output logic                       last_block,
  output logic [count_bits-1:0]      match_count
);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      block_idx   <= '0;
      match_count <= '0;
    end else begin
      if (clear_counts) begin
        block_idx <= '0;
      end else if (advance_block) begin
        block_idx <= block_idx + 1'b1;  // natural wrap after the last block
      end
      if (clear_counts) begin
        match_count <= '0;
      end else if (match_fire) begin
        match_count <= match_count + 1'b1;  // counts 0..32, no overflow in 6 bits
      end
    end
  end

  assign last_block = (block_idx == block_idx_bits'(blocks_per_scan - 1));

endmodule

`default_nettype wire

// File: block_matcher.sv
// compares all pages of a block against the enabled patterns in one cycle
// pattern_count 0 enables no pattern, counts above num_patterns enable all of them
// patterns and the enable mask are taken on load_patterns and held for the whole scan
// hit_vec bit i belongs to page slice i, page 0 sits in the lowest bits of block_data
`default_nettype none

module block_matcher import match_pkg::*; (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         load_patterns,
  input  wire  [pcount_bits-1:0]      pattern_count,
  input  wire  [page_bits-1:0]        pattern_0,
  input  wire  [page_bits-1:0]        pattern_1,
  input  wire  [page_bits-1:0]        pattern_2,
  input  wire  [page_bits-1:0]        pattern_3,
  input  wire                         load_block,
  input  wire  [block_bits-1:0]       block_data,
  output logic [pages_per_block-1:0]  hit_vec
);

  logic [page_bits-1:0]       pat_q [num_patterns];  // stored patterns
  logic [num_patterns-1:0]    pat_en;                // one-hot style thermometer mask
  logic [pages_per_block-1:0] hit_d;                 // compare result of the current block

  // enable mask, slot j active when count > j
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pat_en <= '0;
    end else if (load_patterns) begin
      for (int j = 0; j < num_patterns; j++) begin
        pat_en[j] <= (pattern_count > pcount_bits'(j));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_patterns) begin
      pat_q[0] <= pattern_0;
      pat_q[1] <= pattern_1;
      pat_q[2] <= pattern_2;
      pat_q[3] <= pattern_3;
    end
  end

  // page hits when it equals any enabled pattern
  always_comb begin
    hit_d = '0;
    for (int i = 0; i < pages_per_block; i++) begin
      for (int j = 0; j < num_patterns; j++) begin
        if (pat_en[j] && (block_data[i*page_bits +: page_bits] == pat_q[j])) begin
          hit_d[i] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_block) hit_vec <= hit_d;  // valid from the cycle after the handshake
  end

endmodule

`default_nettype wire

// File: hit_serializer.sv
// sends the hits of one block as global page numbers, lowest page first
// in the cycle after load_block the fresh hit vector is used directly,
// from then on the pending register holds the pages still to send
// match_page and match_valid hold steady until match_ready takes them
`default_nettype none

module hit_serializer import match_pkg::*; (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         load_block,
  input  wire  [pages_per_block-1:0]  hit_vec,
  input  wire  [block_idx_bits-1:0]   block_idx,
  input  wire                         match_ready,
  output logic [page_num_bits-1:0]    match_page,
  output logic                        match_valid,
  output logic                        hits_left
);

  logic                       fresh;        // hit_vec was registered on the last edge
  logic [pages_per_block-1:0] pending_q;    // pages not yet sent
  logic [pages_per_block-1:0] pending;      // view used this cycle
  logic [page_sel_bits-1:0]   low_sel;      // lowest pending page
  logic                       fire;

  assign pending = fresh ? hit_vec : pending_q;

  // priority pick, the last assignment wins so the scan runs downwards
  always_comb begin
    low_sel = '0;
    for (int i = pages_per_block - 1; i >= 0; i--) begin
      if (pending[i]) low_sel = page_sel_bits'(i);
    end
  end

  assign match_valid = |pending;
  assign hits_left   = |pending;
  assign fire        = match_valid & match_ready;
  assign match_page  = {block_idx, low_sel};  // block_idx * pages_per_block + page

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      fresh     <= 1'b0;
      pending_q <= '0;
    end else begin
      fresh     <= load_block;
      pending_q <= fire ? (pending & (pending - 1'b1)) : pending;  // drop lowest set bit
    end
  end

endmodule

`default_nettype wire

// File: pattern_scan_top.sv
// multi-pattern page scanner, 4 blocks of 8 twelve bit pages per scan
// host starts a scan with start plus patterns, then feeds blocks on a valid/ready pair
// matching pages leave as global page numbers on a second valid/ready pair
// block_data must stay stable while block_valid is high and block_ready low
// match_count is valid from the scan_done pulse until the next start
`default_nettype none

module pattern_scan_top import match_pkg::*; (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       start,
  input  wire  [pcount_bits-1:0]    pattern_count,
  input  wire  [page_bits-1:0]      pattern_0,
  input  wire  [page_bits-1:0]      pattern_1,
  input  wire  [page_bits-1:0]      pattern_2,
  input  wire  [page_bits-1:0]      pattern_3,
  input  wire  [block_bits-1:0]     block_data,
  input  wire                       block_valid,
  input  wire                       match_ready,
  output logic                      block_ready,
  output logic [page_num_bits-1:0]  match_page,
  output logic                      match_valid,
  output logic [count_bits-1:0]     match_count,
  output logic                      scan_done,
  output logic                      busy
);

  logic                       load_patterns;
  logic                       clear_counts;
  logic                       load_block;
  logic                       advance_block;
  logic                       last_block;
  logic                       hits_left;
  logic                       match_fire;
  logic [block_idx_bits-1:0]  block_idx;
  logic [pages_per_block-1:0] hit_vec;

  assign match_fire = match_valid & match_ready;  // one page leaves

  scan_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .block_valid   (block_valid),
    .last_block    (last_block),
    .hits_left     (hits_left),
    .block_ready   (block_ready),
    .load_patterns (load_patterns),
    .clear_counts  (clear_counts),
    .load_block    (load_block),
    .advance_block (advance_block),
    .scan_done     (scan_done),
    .busy          (busy)
  );

  block_counter u_counter (
    .clk           (clk),
    .rst           (rst),
    .clear_counts  (clear_counts),
    .advance_block (advance_block),
    .match_fire    (match_fire),
    .block_idx     (block_idx),
    .last_block    (last_block),
    .match_count   (match_count)
  );

  block_matcher u_matcher (
    .clk           (clk),
    .rst           (rst),
    .load_patterns (load_patterns),
    .pattern_count (pattern_count),
    .pattern_0     (pattern_0),
    .pattern_1     (pattern_1),
    .pattern_2     (pattern_2),
    .pattern_3     (pattern_3),
    .load_block    (load_block),
    .block_data    (block_data),
    .hit_vec       (hit_vec)
  );

  hit_serializer u_serializer (
    .clk         (clk),
    .rst         (rst),
    .load_block  (load_block),
    .hit_vec     (hit_vec),
    .block_idx   (block_idx),
    .match_ready (match_ready),
    .match_page  (match_page),
    .match_valid (match_valid),
    .hits_left   (hits_left)
  );

endmodule

`default_nettype wire

// File: tb_pattern_scan.sv
// self-checking testbench for the page scanner
// stimulus and expected page lists come from pattern_scan_tests.txt, read from the project root
// match_ready is randomized by a 16 bit Galois LFSR, one step per cycle
// stops at the first mismatch or timeout
`default_nettype none

module tb_pattern_scan import match_pkg::*; ();

  localparam int mem_words  = 128;   // room for the whole test file
  localparam int max_cycles = 2000;  // per scan

  logic                     clk;
  logic                     rst;
  logic                     start;
  logic [pcount_bits-1:0]   pattern_count;
  logic [page_bits-1:0]     pattern_0;
  logic [page_bits-1:0]     pattern_1;
  logic [page_bits-1:0]     pattern_2;
  logic [page_bits-1:0]     pattern_3;
  logic [block_bits-1:0]    block_data;
  logic                     block_valid;
  logic                     match_ready;
  logic                     block_ready;
  logic [page_num_bits-1:0] match_page;
  logic                     match_valid;
  logic [count_bits-1:0]    match_count;
  logic                     scan_done;
  logic                     busy;

  logic [block_bits-1:0] tests [mem_words];  // raw words of the test file
  logic [15:0]           lfsr;
  int                    ptr;                 // read position in tests
  int                    num_scans;

  pattern_scan_top UUT (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .pattern_count (pattern_count),
    .pattern_0     (pattern_0),
    .pattern_1     (pattern_1),
    .pattern_2     (pattern_2),
    .pattern_3     (pattern_3),
    .block_data    (block_data),
    .block_valid   (block_valid),
    .match_ready   (match_ready),
    .block_ready   (block_ready),
    .match_page    (match_page),
    .match_valid   (match_valid),
    .match_count   (match_count),
    .scan_done     (scan_done),
    .busy          (busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // period 40
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);  // taps 16,14,13,11
  endfunction

  task automatic report_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("error: %s expected %h got %h", name, exp, act);
    report_failure();
  endtask

  task automatic text_error(input string msg);
    $display("%s", msg);
    report_failure();
  endtask

  task automatic run_scan();
    logic [block_bits-1:0]    blocks [blocks_per_scan];
    logic [page_num_bits-1:0] exp_pages [$];
    logic [page_num_bits-1:0] held_page;  // page seen in a stalled cycle
    logic                     stalled;
    logic                     finished;
    int                       exp_n;
    int                       blk;
    int                       got;
    int                       cycles;
    for (int b = 0; b < blocks_per_scan; b++) blocks[b] = tests[ptr + 5 + b];
    exp_n = int'(tests[ptr + 9]);
    for (int i = 0; i < exp_n; i++) exp_pages.push_back(tests[ptr + 10 + i][page_num_bits-1:0]);
    assert (!busy) else value_error("busy", 32'h0, 32'(busy));
    start         <= 1'b1;
    pattern_count <= tests[ptr][pcount_bits-1:0];
    pattern_0     <= tests[ptr + 1][page_bits-1:0];
    pattern_1     <= tests[ptr + 2][page_bits-1:0];
    pattern_2     <= tests[ptr + 3][page_bits-1:0];
    pattern_3     <= tests[ptr + 4][page_bits-1:0];
    block_valid   <= 1'b1;       // first block offered right away
    block_data    <= blocks[0];
    blk = 0;
    got = 0;
    cycles = 0;
    stalled = 1'b0;
    held_page = '0;
    finished = 1'b0;
    while (!finished) begin
      @(posedge clk);
      start <= 1'b0;
      cycles++;
      assert (cycles < max_cycles) else text_error("timeout while waiting for scan_done");
      assert (busy || cycles == 1)  // start cycle itself is still idle
        else value_error("busy", 32'h1, 32'(busy));
      if (stalled) begin  // page must hold until it is taken
        assert (match_valid) else value_error("match_valid", 32'h1, 32'(match_valid));
        assert (match_page == held_page)
          else value_error("match_page", 32'(held_page), 32'(match_page));
      end
      assert (!(block_ready && blk == blocks_per_scan))
        else value_error("block_ready", 32'h0, 32'(block_ready));
      if (block_valid && block_ready) begin
        blk++;
        block_valid <= (blk < blocks_per_scan);
        if (blk < blocks_per_scan) block_data <= blocks[blk];
      end
      if (match_valid && match_ready) begin
        assert (got < exp_n) else text_error("more pages were sent than expected");
        assert (match_page == exp_pages[got])
          else value_error("match_page", 32'(exp_pages[got]), 32'(match_page));
        got++;
      end
      stalled   = match_valid && !match_ready;
      held_page = match_page;
      if (scan_done) begin
        assert (got == exp_n) else text_error("scan_done came before all expected pages");
        assert (match_count == count_bits'(exp_n))
          else value_error("match_count", 32'(exp_n), 32'(match_count));
        finished = 1'b1;
      end
      match_ready <= lfsr[0];  // one bit per cycle
      lfsr = lfsr_next(lfsr);
    end
    @(posedge clk);
    assert (!scan_done) else value_error("scan_done", 32'h0, 32'(scan_done));
    assert (!busy) else value_error("busy", 32'h0, 32'(busy));
    ptr += 10 + exp_n;  // next record
  endtask

  initial begin
    rst           <= 1'b0;
    start         <= 1'b0;
    pattern_count <= '0;
    pattern_0     <= '0;
    pattern_1     <= '0;
    pattern_2     <= '0;
    pattern_3     <= '0;
    block_data    <= '0;
    block_valid   <= 1'b0;
    match_ready   <= 1'b0;
    lfsr          = 16'd32102;
    $readmemh("pattern_scan_tests.txt", tests);
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    assert (!block_ready) else value_error("block_ready", 32'h0, 32'(block_ready));
    assert (!match_valid) else value_error("match_valid", 32'h0, 32'(match_valid));
    assert (!scan_done) else value_error("scan_done", 32'h0, 32'(scan_done));
    assert (!busy) else value_error("busy", 32'h0, 32'(busy));
    num_scans = int'(tests[0]);
    assert (num_scans > 0) else text_error("the test file holds no scans");
    ptr = 1;
    for (int s = 0; s < num_scans; s++) run_scan();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: pattern_scan_tests.txt
// record: pattern_count pattern_0 pattern_1 pattern_2 pattern_3, then four blocks of 96 bits
// (page 7 leftmost, page 0 rightmost), then match count and expected global page numbers, hex
5
// four patterns active
4 abc 123 456 789
000abc111222123333444456
789789789789789789789789
555555555555555555555555
123000000000000000000001
c 0 3 6 8 9 a b c d e f 1f
// count 1, only abc matches
1 abc 123 456 789
123456789abc123456789abc
789456123789456123789456
abcabcabcabcabcabcabcabc
000000000000000000000abc
b 0 4 10 11 12 13 14 15 16 17 18
// count 0, no page can match
0 000 fff 0f0 f0f
000fff0f0f0f000fff0f0f0f
000000000000000000000000
fff000fff000fff000fff000
0f0f0f0f0f0f0f0f0f0f0f0f
0
// count 6 acts as 4
6 111 222 333 444
444333222111444333222111
000000000000000000000000
000000000444000000000000
111000000000000000000000
a 0 1 2 3 4 5 6 7 14 1f
// count 2, ccc and ddd stay inactive
2 aaa bbb ccc ddd
dddcccbbbaaadddcccbbbaaa
cccdddcccdddcccdddcccddd
000000000000000000000000
bbb000000000000000000000
5 0 1 4 5 1f

// File: all.f
match_pkg.sv
scan_fsm.sv
block_counter.sv
block_matcher.sv
hit_serializer.sv
pattern_scan_top.sv
tb_pattern_scan.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the page scanner testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_pattern_scan -f all.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "test run failed"; exit 1; }
exit 0
